// ==== logic/echo_defs.svh ====
// echo unit build constants
// bit timing, frame buffer sizing and tail character

`ifndef ECHO_DEFS_SVH
`define ECHO_DEFS_SVH

// system clocks per serial bit
`define CLKS_PER_BIT 16

// idle clocks after the last stored byte before a frame closes
`define IDLE_TIMEOUT_CLKS (20 * `CLKS_PER_BIT)

// buffer entries, two of them kept for the tail
`define FRAME_DEPTH 64

// appended twice at the end of every frame
`define TAIL_CHAR 8'h26

// stop bits sent per echoed character
`define TX_STOP_BITS 2

`endif

// ==== logic/uart_pkg.sv ====
// serial line types
// data byte and the rx/tx state encodings

`default_nettype none

package uart_pkg;

	localparam int unsigned UART_BYTE_W = 8;

	typedef logic [UART_BYTE_W-1:0] uart_byte_t;

	// receiver walks start, 8 data bits, one stop bit
	typedef enum logic [1:0] {
		rxs_idle,
		rxs_start,
		rxs_data,
		rxs_stop
	} uart_rx_state_t;

	typedef enum logic [1:0] {
		txs_idle,
		txs_start,
		txs_data,
		txs_stop // may span several bit periods
	} uart_tx_state_t;

endpackage

`default_nettype wire

// ==== logic/echo_pkg.sv ====
// frame handling types
// buffer index, byte count and replayer states

`default_nettype none

`include "echo_defs.svh"

package echo_pkg;

	localparam int unsigned FRAME_ADDR_W = $clog2(`FRAME_DEPTH);

	// extra bit so a full buffer count fits
	typedef logic [FRAME_ADDR_W:0]   frame_len_t;
	typedef logic [FRAME_ADDR_W-1:0] frame_addr_t;

	typedef enum logic [1:0] {
		rps_idle,
		rps_send,      // load byte, strobe the transmitter
		rps_wait_done  // character on the line
	} replay_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
// uart receiver, 8N1
// samples each bit at its middle and strobes the byte after a good stop bit

`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module uart_rx import uart_pkg::*; (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        rxd,
	output uart_byte_t rx_data,
	output logic       rx_valid
);

	localparam int unsigned CNT_W    = $clog2(`CLKS_PER_BIT);
	localparam int unsigned HALF_BIT = `CLKS_PER_BIT / 2 - 1;
	localparam int unsigned FULL_BIT = `CLKS_PER_BIT - 1;

	logic             rxd_meta;
	logic             rxd_sync;
	uart_rx_state_t   state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift_q;
	logic             half_end;
	logic             bit_end;

	// two-flop synchronizer, idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign half_end = (clk_cnt == CNT_W'(HALF_BIT));
	assign bit_end  = (clk_cnt == CNT_W'(FULL_BIT));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rxs_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rxs_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!rxd_sync)
						state <= rxs_start;
				end
				rxs_start: begin
					if (half_end) begin
						clk_cnt <= '0;
						state   <= rxd_sync ? rxs_idle : rxs_data; // glitch, not a start bit
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				rxs_data: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= rxs_stop;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				rxs_stop: begin
					if (bit_end) begin
						clk_cnt  <= '0;
						rx_valid <= rxd_sync; // low stop bit gives no strobe
						state    <= rxs_idle;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= rxs_idle;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == rxs_data && bit_end)
			shift_q <= {rxd_sync, shift_q[7:1]};
	end

	assign rx_data = shift_q;

endmodule

`default_nettype wire

// ==== logic/frame_collector.sv ====
// frame collector
// stores received bytes, closes the frame after an idle gap with two tail
// characters, and holds it until the replayer releases it

`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module frame_collector import uart_pkg::*, echo_pkg::*; (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  uart_byte_t  rx_data,
	input  wire         rx_valid,
	input  frame_addr_t rd_addr,
	input  wire         frame_release,
	output uart_byte_t  rd_data,
	output logic        frame_ready,
	output frame_len_t  frame_len
);

	localparam int unsigned IDLE_W   = $clog2(`IDLE_TIMEOUT_CLKS + 1);
	localparam frame_len_t  CLIP_LEN = frame_len_t'(`FRAME_DEPTH - 2);

	uart_byte_t        frame_mem [`FRAME_DEPTH];
	frame_len_t        wr_cnt;
	frame_addr_t       wr_addr;
	logic              held;     // frame closed, waiting for release
	logic [IDLE_W-1:0] idle_cnt;
	logic              store;
	logic              timeout;

	assign wr_addr = frame_addr_t'(wr_cnt);

	// room left for the tail, else the byte is clipped
	assign store   = rx_valid && !held && (wr_cnt < CLIP_LEN);
	assign timeout = !held && (wr_cnt != '0) && !rx_valid &&
	                 (idle_cnt == IDLE_W'(`IDLE_TIMEOUT_CLKS));

	// every byte seen restarts the gap, clipped ones too
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			idle_cnt <= '0;
		else if (held || wr_cnt == '0 || rx_valid)
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_cnt      <= '0;
			held        <= 1'b0;
			frame_len   <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= timeout; // one cycle after the close
			if (frame_release) begin
				wr_cnt <= '0;
				held   <= 1'b0;
			end else if (timeout) begin
				wr_cnt    <= wr_cnt + frame_len_t'(2);
				frame_len <= wr_cnt + frame_len_t'(2);
				held      <= 1'b1;
			end else if (store)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (timeout) begin
			frame_mem[wr_addr]        <= `TAIL_CHAR;
			frame_mem[wr_addr + 1'b1] <= `TAIL_CHAR;
		end else if (store)
			frame_mem[wr_addr] <= rx_data;
	end

	assign rd_data = frame_mem[rd_addr]; // async read for the replayer

endmodule

`default_nettype wire

// ==== logic/frame_replayer.sv ====
// frame replayer
// sends the held frame byte by byte through the transmitter, then releases it

`timescale 1ns/1ps
`default_nettype none

module frame_replayer import uart_pkg::*, echo_pkg::*; (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire         frame_ready,
	input  frame_len_t  frame_len,
	input  uart_byte_t  rd_data,
	input  wire         tx_done,
	output frame_addr_t rd_addr,
	output uart_byte_t  tx_data,
	output logic        tx_start,
	output logic        frame_release,
	output logic        echo_busy
);

	replay_state_t state;
	frame_addr_t   rd_idx;
	frame_len_t    len_q;
	logic          last_byte;

	assign rd_addr   = rd_idx;
	assign last_byte = ((frame_len_t'(rd_idx) + frame_len_t'(1)) == len_q);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= rps_idle;
			rd_idx        <= '0;
			len_q         <= '0;
			tx_start      <= 1'b0;
			frame_release <= 1'b0;
			echo_busy     <= 1'b0;
		end else begin
			tx_start      <= 1'b0;
			frame_release <= 1'b0;
			case (state)
				rps_idle: begin
					if (frame_ready) begin
						len_q     <= frame_len;
						rd_idx    <= '0;
						echo_busy <= 1'b1;
						state     <= rps_send;
					end
				end
				rps_send: begin
					tx_start <= 1'b1; // transmitter is idle here
					state    <= rps_wait_done;
				end
				rps_wait_done: begin
					if (tx_done) begin
						if (last_byte) begin
							frame_release <= 1'b1;
							echo_busy     <= 1'b0;
							state         <= rps_idle;
						end else begin
							rd_idx <= rd_idx + 1'b1;
							state  <= rps_send;
						end
					end
				end
				default: state <= rps_idle;
			endcase
		end
	end

	// byte lines up with the tx_start strobe
	always_ff @(posedge sys_clk) begin
		if (state == rps_send)
			tx_data <= rd_data;
	end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// uart transmitter
// start bit, 8 data bits lsb first, configurable stop bits

`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module uart_tx import uart_pkg::*; (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  uart_byte_t tx_data,
	input  wire        tx_start,
	output logic       txd,
	output logic       tx_done
);

	localparam int unsigned CNT_W    = $clog2(`CLKS_PER_BIT);
	localparam int unsigned FULL_BIT = `CLKS_PER_BIT - 1;

	uart_tx_state_t   state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;  // data bit, then stop bit number
	uart_byte_t       shift_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(FULL_BIT));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= txs_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				txs_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					txd     <= !tx_start; // start bit right after the strobe
					if (tx_start)
						state <= txs_start;
				end
				txs_start: begin
					if (bit_end) begin
						clk_cnt <= '0;
						txd     <= shift_q[0];
						state   <= txs_data;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				txs_data: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) begin
							bit_idx <= '0;
							txd     <= 1'b1;
							state   <= txs_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= shift_q[1]; // shift lands this edge
						end
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				txs_stop: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == 3'(`TX_STOP_BITS - 1)) begin
							tx_done <= 1'b1;
							state   <= txs_idle;
						end else
							bit_idx <= bit_idx + 1'b1;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= txs_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == txs_idle && tx_start)
			shift_q <= tx_data;
		else if (state == txs_data && bit_end)
			shift_q <= {1'b0, shift_q[7:1]};
	end

endmodule

`default_nettype wire

// ==== logic/uart_echo_top.sv ====
// serial echo unit top
// rx -> frame collector -> frame replayer -> tx

`timescale 1ns/1ps
`default_nettype none

module uart_echo_top import uart_pkg::*, echo_pkg::*; (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        uart_rxd,
	output logic       uart_txd,
	output frame_len_t frame_len,
	output logic       echo_busy
);

	uart_byte_t  rx_data;
	logic        rx_valid;
	frame_addr_t rd_addr;
	uart_byte_t  rd_data;
	logic        frame_ready;
	logic        frame_release;
	uart_byte_t  tx_data;
	logic        tx_start;
	logic        tx_done;

	uart_rx uart_rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rxd),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid)
	);

	frame_collector frame_collector_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.rd_addr       (rd_addr),
		.frame_release (frame_release),
		.rd_data       (rd_data),
		.frame_ready   (frame_ready),
		.frame_len     (frame_len)  // also the status port
	);

	frame_replayer frame_replayer_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.frame_ready   (frame_ready),
		.frame_len     (frame_len),
		.rd_data       (rd_data),
		.tx_done       (tx_done),
		.rd_addr       (rd_addr),
		.tx_data       (tx_data),
		.tx_start      (tx_start),
		.frame_release (frame_release),
		.echo_busy     (echo_busy)
	);

	uart_tx uart_tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.txd       (uart_txd),
		.tx_done   (tx_done)
	);

endmodule

`default_nettype wire

// ==== bench/uart_echo_tb.sv ====
// echo unit testbench
// random frames go in on the rx line, the echo is decoded from the tx line
// and compared with a byte queue model

`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module uart_echo_tb import uart_pkg::*, echo_pkg::*; ();

	localparam int CLK_NS     = 4;
	localparam int BIT_CLKS   = `CLKS_PER_BIT;
	localparam int IDLE_CLKS  = `IDLE_TIMEOUT_CLKS;
	localparam int CHAR_CLKS  = (1 + 8 + `TX_STOP_BITS) * BIT_CLKS;
	localparam int CLIP_BYTES = `FRAME_DEPTH - 2;
	localparam int GAP_MAX    = IDLE_CLKS - 12 * BIT_CLKS; // valid to valid stays under timeout
	localparam int NUM_RANDOM = 10;
	localparam int BUSY_FRAME = 4;                         // also sends into the held frame
	localparam int NUM_FRAMES = NUM_RANDOM + 2;
	localparam longint WATCHDOG_NS =
		longint'(NUM_FRAMES) * (22 * 2 * 11 * BIT_CLKS + IDLE_CLKS) * CLK_NS * 2;

	logic        sys_clk;
	logic        sys_rst_n;
	logic        uart_rxd;
	logic        uart_txd;
	frame_len_t  frame_len;
	logic        echo_busy;
	logic [31:0] lfsr_q;
	uart_byte_t  model_q [$]; // expected echo
	uart_byte_t  echo_q [$];  // decoded from uart_txd

	uart_echo_top uart_echo_top_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd),
		.frame_len (frame_len),
		.echo_busy (echo_busy)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: %s is %02h, expected %02h", $time, what, got, exp));
	endtask

	task automatic check_len(input frame_len_t got, input frame_len_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: frame_len is %0d, expected %0d", $time, got, exp));
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			val    = {val[30:0], lfsr_q[0]};
		end
	endtask

	// 8N1 character on the rx line
	task automatic send_byte(input uart_byte_t b);
		logic [9:0] frame_bits;
		frame_bits = {1'b1, b, 1'b0}; // stop, data, start
		for (int k = 0; k < 10; k++) begin
			@(posedge sys_clk);
			uart_rxd <= frame_bits[k];
			repeat (BIT_CLKS - 1) @(posedge sys_clk);
		end
	endtask

	task automatic wait_busy(input logic level, input int max_clks);
		int n;
		n = 0;
		while (echo_busy !== level) begin
			@(negedge sys_clk);
			n++;
			if (n > max_clks)
				abort_run($sformatf("timed out waiting for echo_busy to go %0b", level));
		end
	endtask

	task automatic run_frame(input int n, input bit gaps, input int extra);
		logic [31:0] r;
		frame_len_t  exp_len;
		model_q.delete();
		for (int i = 0; i < n; i++) begin
			@(negedge sys_clk);
			check_level(echo_busy, 1'b0, "echo_busy during frame input"); // no early echo
			draw_bits(8, r);
			send_byte(uart_byte_t'(r[7:0]));
			if (model_q.size() < CLIP_BYTES)
				model_q.push_back(uart_byte_t'(r[7:0]));
			if (gaps && i < n - 1) begin
				draw_bits(8, r);
				repeat (int'(r % GAP_MAX)) @(posedge sys_clk);
			end
		end
		@(negedge sys_clk);
		check_level(echo_busy, 1'b0, "echo_busy after the last input byte");
		if (echo_q.size() != 0)
			abort_run("echo output started before the frame was closed");
		exp_len = frame_len_t'(model_q.size() + 2);
		model_q.push_back(`TAIL_CHAR);
		model_q.push_back(`TAIL_CHAR);
		wait_busy(1'b1, IDLE_CLKS + 4 * BIT_CLKS);
		check_len(frame_len, exp_len);
		for (int e = 0; e < extra; e++) begin
			draw_bits(8, r);
			send_byte(uart_byte_t'(r[7:0])); // dropped, frame is held
			@(negedge sys_clk);
			check_level(echo_busy, 1'b1, "echo_busy while sending into a held frame");
		end
		wait_busy(1'b0, int'(exp_len) * (CHAR_CLKS + 4) + 16);
		if (echo_q.size() != model_q.size())
			abort_run($sformatf("echoed %0d characters, expected %0d",
				echo_q.size(), model_q.size()));
		while (model_q.size() != 0)
			check_byte(echo_q.pop_front(), model_q.pop_front(), "echoed character");
	endtask

	// mid-bit sampling of uart_txd, sampled on falling edges
	initial begin : tx_monitor
		uart_byte_t b;
		@(posedge sys_rst_n);
		forever begin
			@(negedge sys_clk);
			if (!uart_txd) begin
				repeat (BIT_CLKS / 2) @(negedge sys_clk);
				check_level(uart_txd, 1'b0, "start bit");
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge sys_clk);
					b[i] = uart_txd;
				end
				for (int s = 0; s < `TX_STOP_BITS; s++) begin
					repeat (BIT_CLKS) @(negedge sys_clk);
					check_level(uart_txd, 1'b1, "stop bit");
				end
				echo_q.push_back(b);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the test sequence finished");
	end

	initial begin : test_main
		logic [31:0] r;
		sys_rst_n = 1'b0;
		uart_rxd  = 1'b1;
		lfsr_q    = 32'h0984_60c9;
		repeat (2) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		check_level(uart_txd, 1'b1, "uart_txd after reset");
		check_level(echo_busy, 1'b0, "echo_busy after reset");
		check_len(frame_len, '0);
		// odd frames get random gaps between bytes
		for (int f = 0; f < NUM_RANDOM; f++) begin
			draw_bits(5, r);
			run_frame(1 + int'(r % 20), f[0], (f == BUSY_FRAME) ? 2 : 0);
		end
		run_frame(`FRAME_DEPTH + 3, 1'b0, 0); // clipped to depth minus 2
		repeat (2 * IDLE_CLKS) @(negedge sys_clk); // stray bytes would close a frame here
		check_level(echo_busy, 1'b0, "echo_busy after the last frame");
		if (echo_q.size() != 0)
			abort_run("unexpected output after the last frame");
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/uart_pkg.sv
logic/echo_pkg.sv
logic/uart_rx.sv
logic/frame_collector.sv
logic/frame_replayer.sv
logic/uart_tx.sv
logic/uart_echo_top.sv
bench/uart_echo_tb.sv

// ==== Makefile ====
# Verilator build and run for the serial echo unit

VERILATOR   ?= verilator
TOP         ?= uart_echo_tb
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing -Wno-fatal
EXTRA_FLAGS ?=

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
